// ==== project.f ====
common/stq_pkg.sv
common/stq_view_if.sv
store_queue/stq_entry_array.sv
store_queue/stq_fwd_check.sv
store_queue/stq_drain.sv
store_queue/stq_top.sv
dv/stq_assertions.sv
dv/stq_tb.sv

// ==== Makefile ====
TOP := stq_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) \
		--Mdir obj_dir -o V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== dv/stq_tb.sv ====
`timescale 1ns/1ps

module stq_tb;

  localparam int DEPTH    = stq_pkg::DEPTH_DEFAULT;
  localparam int IDX_W    = $clog2(DEPTH);
  localparam int N_RAND   = 400;
  localparam int TEST_LEN = (3 * DEPTH + 10) + 40 + (N_RAND + 6 * DEPTH);
  localparam int LIMIT    = TEST_LEN + 200;

  typedef struct {
    logic [IDX_W-1:0] idx;
    logic             upd;
    logic             cmt;
    stq_pkg::size_e   size;
    stq_pkg::paddr_t  paddr;
    stq_pkg::data_t   data;
  } ref_ent_t;

  logic             i_clk = 1'b0;
  logic             i_reset_n = 1'b0;
  logic             i_alloc_valid = 1'b0;
  logic             i_upd_valid = 1'b0;
  logic [IDX_W-1:0] i_upd_idx = '0;
  stq_pkg::paddr_t  i_upd_paddr = '0;
  stq_pkg::size_e   i_upd_size = stq_pkg::SIZE_B;
  stq_pkg::data_t   i_upd_data = '0;
  logic             i_commit_valid = 1'b0;
  logic             i_fwd_valid = 1'b0;
  stq_pkg::paddr_t  i_fwd_paddr = '0;
  stq_pkg::size_e   i_fwd_size = stq_pkg::SIZE_B;
  logic             i_stb_full = 1'b0;

  logic [IDX_W-1:0] o_alloc_idx;
  logic             o_full;
  logic             o_fwd_hit;
  logic             o_stb_valid;
  logic             o_credit_valid;
  stq_pkg::strb_t   o_fwd_strb;
  stq_pkg::strb_t   o_stb_strb;
  stq_pkg::data_t   o_fwd_data;
  stq_pkg::data_t   o_stb_data;
  stq_pkg::paddr_t  o_stb_paddr;
  logic [1:0]       o_credit_cnt;

  ref_ent_t         m_q[$];          // Oldest entry first
  logic [IDX_W-1:0] m_in = '0;
  logic [31:0]      lfsr_state = 32'hf9ae_72eb;
  int               n_err = 0;
  int               n_chk = 0;
  int               n_cyc = 0;
  int               alloc_total = 0;
  int               credit_sum = 0;

  stq_top #(.DEPTH(DEPTH)) stq_top_i (.*);

  always #10 i_clk = ~i_clk;

  // ========================================
  // Helpers and reference functions
  // ========================================
  function automatic logic [63:0] rand_bits(int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      v = {v[62:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Naturally aligned address in one of a few lines
  function automatic stq_pkg::paddr_t make_addr(int line, stq_pkg::size_e size, logic [2:0] off);
    logic [2:0] aligned;
    aligned = (off >> size) << size;
    return stq_pkg::paddr_t'(32'h1000 + line * 8) + stq_pkg::paddr_t'(aligned);
  endfunction

  function automatic logic covers(stq_pkg::size_e size, stq_pkg::paddr_t a, int b);
    int off;
    off = int'(a[2:0]);
    return (b >= off) && (b < off + (1 << int'(size)));
  endfunction

  function automatic int first_uncommitted();
    for (int i = 0; i < m_q.size(); i++) begin
      if (!m_q[i].cmt) return i;
    end
    return -1;
  endfunction

  function automatic int first_unupdated();
    for (int i = 0; i < m_q.size(); i++) begin
      if (!m_q[i].upd) return i;
    end
    return -1;
  endfunction

  // Walks oldest to youngest so the youngest store owns each byte
  function automatic void ref_forward(input logic valid, input stq_pkg::paddr_t a,
                                      input stq_pkg::size_e size,
                                      output stq_pkg::strb_t s, output stq_pkg::data_t d);
    s = '0;
    d = '0;
    for (int i = 0; i < m_q.size(); i++) begin
      if (valid && m_q[i].upd && m_q[i].paddr[31:3] == a[31:3]) begin
        for (int b = 0; b < 8; b++) begin
          if (covers(m_q[i].size, m_q[i].paddr, b) && covers(size, a, b)) begin
            s[b]        = 1'b1;
            d[b*8 +: 8] = m_q[i].data[(b - int'(m_q[i].paddr[2:0])) * 8 +: 8];
          end
        end
      end
    end
  endfunction

  function automatic void ref_drain(output logic v, output stq_pkg::paddr_t a,
                                    output stq_pkg::strb_t s, output stq_pkg::data_t d,
                                    output logic [1:0] c);
    int n;
    v = 1'b0;
    a = '0;
    s = '0;
    d = '0;
    c = 2'd1;
    if (m_q.size() > 0 && m_q[0].upd && m_q[0].cmt) begin
      n = 1;
      if (m_q.size() > 1 && m_q[1].upd && m_q[1].cmt && m_q[1].paddr[31:3] == m_q[0].paddr[31:3])
        n = 2;
      v = 1'b1;
      c = 2'(n);
      a = {m_q[0].paddr[31:3], 3'b000};
      for (int i = 0; i < n; i++) begin
        for (int b = 0; b < 8; b++) begin
          if (covers(m_q[i].size, m_q[i].paddr, b)) begin
            s[b]        = 1'b1;
            d[b*8 +: 8] = m_q[i].data[(b - int'(m_q[i].paddr[2:0])) * 8 +: 8];
          end
        end
      end
    end
  endfunction

  task automatic report(string name, logic [63:0] exp, logic [63:0] act);
    n_err++;
    $display("CHECK FAILED t=%0t %s expected=%h actual=%h", $time, name, exp, act);
  endtask

  task automatic tick();
    @(posedge i_clk);
    #2;
    i_alloc_valid  = 1'b0;
    i_upd_valid    = 1'b0;
    i_commit_valid = 1'b0;
  endtask

  task automatic drive_update(int pos, int line, stq_pkg::size_e size);
    i_upd_valid = 1'b1;
    i_upd_idx   = m_q[pos].idx;
    i_upd_size  = size;
    i_upd_paddr = make_addr(line, size, 3'(rand_bits(3)));
    i_upd_data  = rand_bits(64);
  endtask

  // Commits and updates whatever is left until the queue is empty
  task automatic drain_all();
    int pos;
    i_stb_full = 1'b0;
    while (m_q.size() != 0) begin
      if (first_uncommitted() >= 0) i_commit_valid = 1'b1;
      pos = first_unupdated();
      if (pos >= 0) drive_update(pos, int'(rand_bits(2)), stq_pkg::SIZE_W);
      tick();
    end
  endtask

  // ========================================
  // Reference model stepped at each edge
  // ========================================
  always @(posedge i_clk or negedge i_reset_n) begin
    logic            d_v;
    stq_pkg::paddr_t d_a;
    stq_pkg::strb_t  d_s;
    stq_pkg::data_t  d_d;
    logic [1:0]      d_c;
    logic            was_full;
    int              pos;
    if (!i_reset_n) begin
      m_q.delete();
      m_in = '0;
    end else begin
      ref_drain(d_v, d_a, d_s, d_d, d_c);
      was_full = (m_q.size() == DEPTH);
      if (d_v && !i_stb_full) begin
        repeat (int'(d_c)) m_q.delete(0);
      end
      pos = first_uncommitted();
      if (i_commit_valid && pos >= 0) m_q[pos].cmt = 1'b1;
      for (int i = 0; i < m_q.size(); i++) begin
        if (i_upd_valid && m_q[i].idx == i_upd_idx) begin
          m_q[i].upd   = 1'b1;
          m_q[i].size  = i_upd_size;
          m_q[i].paddr = i_upd_paddr;
          m_q[i].data  = i_upd_data;
        end
      end
      if (i_alloc_valid && !was_full) begin
        m_q.push_back('{idx: m_in, upd: 1'b0, cmt: 1'b0, size: stq_pkg::SIZE_B,
                        paddr: '0, data: '0});
        m_in = m_in + IDX_W'(1);
        alloc_total++;
      end
    end
  end

  // Compare at the falling edge with inputs long settled
  always @(negedge i_clk) begin
    logic            e_v;
    stq_pkg::paddr_t e_a;
    stq_pkg::strb_t  e_s;
    stq_pkg::data_t  e_d;
    logic [1:0]      e_c;
    stq_pkg::strb_t  f_s;
    stq_pkg::data_t  f_d;
    if (i_reset_n) begin
      ref_drain(e_v, e_a, e_s, e_d, e_c);
      ref_forward(i_fwd_valid, i_fwd_paddr, i_fwd_size, f_s, f_d);
      n_chk++;
      if (o_alloc_idx !== m_in) report("o_alloc_idx", 64'(m_in), 64'(o_alloc_idx));
      if (o_full !== (m_q.size() == DEPTH))
        report("o_full", 64'(m_q.size() == DEPTH), 64'(o_full));
      if (o_stb_valid !== e_v) report("o_stb_valid", 64'(e_v), 64'(o_stb_valid));
      if (e_v && o_stb_paddr !== e_a) report("o_stb_paddr", 64'(e_a), 64'(o_stb_paddr));
      if (e_v && o_stb_strb !== e_s) report("o_stb_strb", 64'(e_s), 64'(o_stb_strb));
      if (e_v && o_stb_data !== e_d) report("o_stb_data", e_d, o_stb_data);
      if (o_credit_valid !== (e_v && !i_stb_full))
        report("o_credit_valid", 64'(e_v && !i_stb_full), 64'(o_credit_valid));
      if (o_credit_valid && o_credit_cnt !== e_c)
        report("o_credit_cnt", 64'(e_c), 64'(o_credit_cnt));
      if (o_fwd_hit !== (|f_s)) report("o_fwd_hit", 64'(|f_s), 64'(o_fwd_hit));
      if (o_fwd_strb !== f_s) report("o_fwd_strb", 64'(f_s), 64'(o_fwd_strb));
      if (o_fwd_data !== f_d) report("o_fwd_data", f_d, o_fwd_data);
      if (o_credit_valid) credit_sum += int'(o_credit_cnt);
    end
  end

  always @(posedge i_clk) begin
    n_cyc++;
    if (n_cyc > LIMIT) begin
      $display("Timeout: run still going after %0d cycles", LIMIT);
      $display("Done: errors found");
      $finish;
    end
  end

  // ========================================
  // Stimulus
  // ========================================
  initial begin
    repeat (3) @(posedge i_clk);
    #2 i_reset_n = 1'b1;

    // Fill to full, hold under back-pressure, then drain line by line
    i_stb_full = 1'b1;
    for (int k = 0; k < DEPTH; k++) begin
      if (o_alloc_idx !== IDX_W'(k)) report("o_alloc_idx", 64'(k), 64'(o_alloc_idx));
      i_alloc_valid = 1'b1;
      tick();
    end
    for (int k = 0; k < DEPTH; k++) begin
      drive_update(k, 2 * k, stq_pkg::SIZE_D);
      i_commit_valid = 1'b1;
      tick();
    end
    repeat (5) tick();
    drain_all();

    // Four stores in one line with the head committed before its update
    i_stb_full = 1'b1;
    repeat (4) begin
      i_alloc_valid = 1'b1;
      tick();
    end
    i_commit_valid = 1'b1;
    tick();
    repeat (2) tick();
    for (int k = 0; k < 4; k++) begin
      drive_update(k, 0, stq_pkg::size_e'(2'(rand_bits(2))));
      tick();
    end
    // Rest of the line committed so the drain merges pairs
    repeat (3) begin
      i_commit_valid = 1'b1;
      tick();
    end
    for (int k = 0; k < 12; k++) begin
      i_fwd_valid = 1'b1;
      i_fwd_size  = stq_pkg::size_e'(2'(rand_bits(2)));
      i_fwd_paddr = make_addr((k == 11) ? 5 : 0, i_fwd_size, 3'(rand_bits(3)));
      tick();
    end
    i_fwd_valid = 1'b0;
    drain_all();

    // Random traffic over a few lines
    for (int n = 0; n < N_RAND; n++) begin
      if (m_q.size() < DEPTH && rand_bits(1) != 0) i_alloc_valid = 1'b1;
      if (m_q.size() > 0 && rand_bits(1) != 0) begin
        drive_update(int'(rand_bits(3)) % m_q.size(), int'(rand_bits(2)),
                     stq_pkg::size_e'(2'(rand_bits(2))));
      end
      if (first_uncommitted() >= 0 && rand_bits(1) != 0) i_commit_valid = 1'b1;
      i_fwd_valid = (rand_bits(1) != 0);
      i_fwd_size  = stq_pkg::size_e'(2'(rand_bits(2)));
      i_fwd_paddr = make_addr(int'(rand_bits(2)), i_fwd_size, 3'(rand_bits(3)));
      i_stb_full  = (rand_bits(2) == 0);
      tick();
    end
    i_fwd_valid = 1'b0;
    drain_all();

    @(negedge i_clk);
    #1;
    if (credit_sum != alloc_total) report("credit total", 64'(alloc_total), 64'(credit_sum));
    if (o_full !== 1'b0) report("o_full", 64'(0), 64'(o_full));
    if (o_stb_valid !== 1'b0) report("o_stb_valid", 64'(0), 64'(o_stb_valid));
    n_err += stq_top_i.u_stq_assertions.n_fail;
    $display("Checked %0d cycles, %0d errors", n_chk, n_err);
    if (n_err == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== dv/stq_assertions.sv ====
`timescale 1ns/1ps

module stq_assertions #(
  parameter int DEPTH = stq_pkg::DEPTH_DEFAULT
) (
  input logic           i_clk,
  input logic           i_reset_n,
  input logic           i_alloc_valid,
  input logic           o_full,
  input logic           i_commit_valid,
  input logic           o_stb_valid,
  input stq_pkg::strb_t o_stb_strb,
  input logic           o_credit_valid,
  input logic [1:0]     o_credit_cnt
);

  localparam int CNT_W = $clog2(DEPTH) + 1;

  logic [CNT_W-1:0] r_uncmt;     // Allocated but not yet committed
  int               n_fail = 0;  // Failed assertions

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_uncmt <= '0;
    end else begin
      r_uncmt <= r_uncmt + CNT_W'(i_alloc_valid & ~o_full) - CNT_W'(i_commit_valid);
    end
  end

  a_alloc_not_full: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_alloc_valid |-> !o_full) else begin
    $error("allocation while the queue is full");
    n_fail++;
  end

  a_commit_legal: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_commit_valid |-> (r_uncmt != '0)) else begin
    $error("commit with no uncommitted entry");
    n_fail++;
  end

  a_stb_strb: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_stb_valid |-> (o_stb_strb != '0)) else begin
    $error("store buffer request with empty strobe");
    n_fail++;
  end

  a_credit_cnt: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_credit_valid |-> (o_credit_cnt inside {2'd1, 2'd2})) else begin
    $error("bad credit count");
    n_fail++;
  end

endmodule

bind stq_top stq_assertions #(.DEPTH(DEPTH)) u_stq_assertions (
  .i_clk         (i_clk),
  .i_reset_n     (i_reset_n),
  .i_alloc_valid (i_alloc_valid),
  .o_full        (o_full),
  .i_commit_valid(i_commit_valid),
  .o_stb_valid   (o_stb_valid),
  .o_stb_strb    (o_stb_strb),
  .o_credit_valid(o_credit_valid),
  .o_credit_cnt  (o_credit_cnt)
);

// ==== store_queue/stq_top.sv ====
`timescale 1ns/1ps

module stq_top #(
  parameter int DEPTH = stq_pkg::DEPTH_DEFAULT
) (
  input  logic                       i_clk,
  input  logic                       i_reset_n,

  input  logic                       i_alloc_valid,
  output logic [$clog2(DEPTH)-1:0]   o_alloc_idx,
  output logic                       o_full,

  input  logic                       i_upd_valid,
  input  logic [$clog2(DEPTH)-1:0]   i_upd_idx,
  input  stq_pkg::paddr_t            i_upd_paddr,
  input  stq_pkg::size_e             i_upd_size,
  input  stq_pkg::data_t             i_upd_data,

  input  logic                       i_commit_valid,

  input  logic                       i_fwd_valid,
  input  stq_pkg::paddr_t            i_fwd_paddr,
  input  stq_pkg::size_e             i_fwd_size,
  output logic                       o_fwd_hit,
  output stq_pkg::strb_t             o_fwd_strb,
  output stq_pkg::data_t             o_fwd_data,

  output logic                       o_stb_valid,
  output stq_pkg::paddr_t            o_stb_paddr,
  output stq_pkg::strb_t             o_stb_strb,
  output stq_pkg::data_t             o_stb_data,
  input  logic                       i_stb_full,

  output logic                       o_credit_valid,
  output logic [1:0]                 o_credit_cnt
);

  logic       w_release_valid;
  logic [1:0] w_release_cnt;

  stq_view_if #(.DEPTH(DEPTH)) view ();

  stq_entry_array #(.DEPTH(DEPTH)) u_entry_array (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_alloc_valid  (i_alloc_valid),
    .o_alloc_idx    (o_alloc_idx),
    .o_full         (o_full),
    .i_upd_valid    (i_upd_valid),
    .i_upd_idx      (i_upd_idx),
    .i_upd_paddr    (i_upd_paddr),
    .i_upd_size     (i_upd_size),
    .i_upd_data     (i_upd_data),
    .i_commit_valid (i_commit_valid),
    .i_release_valid(w_release_valid),
    .i_release_cnt  (w_release_cnt),
    .view           (view.owner)
  );

  stq_fwd_check #(.DEPTH(DEPTH)) u_fwd_check (
    .i_fwd_valid(i_fwd_valid),
    .i_fwd_paddr(i_fwd_paddr),
    .i_fwd_size (i_fwd_size),
    .o_fwd_hit  (o_fwd_hit),
    .o_fwd_strb (o_fwd_strb),
    .o_fwd_data (o_fwd_data),
    .view       (view.reader)
  );

  stq_drain #(.DEPTH(DEPTH)) u_drain (
    .i_stb_full     (i_stb_full),
    .o_stb_valid    (o_stb_valid),
    .o_stb_paddr    (o_stb_paddr),
    .o_stb_strb     (o_stb_strb),
    .o_stb_data     (o_stb_data),
    .o_credit_valid (o_credit_valid),
    .o_credit_cnt   (o_credit_cnt),
    .o_release_valid(w_release_valid),
    .o_release_cnt  (w_release_cnt),
    .view           (view.reader)
  );

endmodule

// ==== store_queue/stq_drain.sv ====
`timescale 1ns/1ps

module stq_drain #(
  parameter int DEPTH = stq_pkg::DEPTH_DEFAULT
) (
  input  logic              i_stb_full,

  output logic              o_stb_valid,
  output stq_pkg::paddr_t   o_stb_paddr,
  output stq_pkg::strb_t    o_stb_strb,
  output stq_pkg::data_t    o_stb_data,

  output logic              o_credit_valid,
  output logic [1:0]        o_credit_cnt,

  output logic              o_release_valid,
  output logic [1:0]        o_release_cnt,

  stq_view_if.reader        view
);

  localparam int IDX_W = $clog2(DEPTH);
  localparam int OFF_W = stq_pkg::OFF_W;

  logic [IDX_W-1:0]    w_nxt_idx;
  stq_pkg::stq_entry_t w_head;
  stq_pkg::stq_entry_t w_nxt;

  logic w_head_rdy;
  logic w_nxt_rdy;
  logic w_same_line;
  logic w_join;
  logic w_taken;

  stq_pkg::strb_t w_head_mask;
  stq_pkg::strb_t w_nxt_mask;
  stq_pkg::data_t w_head_data;
  stq_pkg::data_t w_nxt_data;
  stq_pkg::data_t w_data;

  // ========================================
  // Head and merge partner
  // ========================================
  assign w_nxt_idx = view.head_idx + IDX_W'(1);
  assign w_head    = view.entries[view.head_idx];
  assign w_nxt     = view.entries[w_nxt_idx];

  assign w_head_rdy  = w_head.valid & w_head.committed & w_head.upd_valid;
  assign w_nxt_rdy   = w_nxt.valid & w_nxt.committed & w_nxt.upd_valid;
  assign w_same_line = (w_head.paddr[stq_pkg::PADDR_W-1:OFF_W] ==
                        w_nxt.paddr[stq_pkg::PADDR_W-1:OFF_W]);
  assign w_join      = w_head_rdy & w_nxt_rdy & w_same_line & (view.count > 1);

  assign w_head_mask = stq_pkg::size_strb(w_head.size) << w_head.paddr[OFF_W-1:0];
  assign w_nxt_mask  = stq_pkg::size_strb(w_nxt.size) << w_nxt.paddr[OFF_W-1:0];
  assign w_head_data = w_head.data << {w_head.paddr[OFF_W-1:0], 3'b000};
  assign w_nxt_data  = w_nxt.data << {w_nxt.paddr[OFF_W-1:0], 3'b000};

  // Younger entry wins on overlapping bytes
  always_comb begin
    w_data = '0;
    for (int b = 0; b < stq_pkg::LINE_B; b++) begin
      if (w_join && w_nxt_mask[b]) begin
        w_data[b*8 +: 8] = w_nxt_data[b*8 +: 8];
      end else if (w_head_mask[b]) begin
        w_data[b*8 +: 8] = w_head_data[b*8 +: 8];
      end
    end
  end

  // ========================================
  // Store buffer request
  // ========================================
  assign o_stb_valid = w_head_rdy;
  assign o_stb_paddr = {w_head.paddr[stq_pkg::PADDR_W-1:OFF_W], {OFF_W{1'b0}}};
  assign o_stb_strb  = w_head_mask | (w_join ? w_nxt_mask : '0);
  assign o_stb_data  = w_data;

  assign w_taken = w_head_rdy & ~i_stb_full;  // Full level holds everything

  assign o_credit_valid  = w_taken;
  assign o_credit_cnt    = w_join ? 2'd2 : 2'd1;
  assign o_release_valid = w_taken;
  assign o_release_cnt   = o_credit_cnt;

endmodule

// ==== store_queue/stq_fwd_check.sv ====
`timescale 1ns/1ps

module stq_fwd_check #(
  parameter int DEPTH = stq_pkg::DEPTH_DEFAULT
) (
  input  logic              i_fwd_valid,
  input  stq_pkg::paddr_t   i_fwd_paddr,
  input  stq_pkg::size_e    i_fwd_size,
  output logic              o_fwd_hit,
  output stq_pkg::strb_t    o_fwd_strb,
  output stq_pkg::data_t    o_fwd_data,

  stq_view_if.reader        view
);

  localparam int IDX_W = $clog2(DEPTH);
  localparam int OFF_W = stq_pkg::OFF_W;

  stq_pkg::strb_t w_ld_mask;
  stq_pkg::strb_t w_ent_mask [DEPTH];
  stq_pkg::data_t w_ent_data [DEPTH];
  logic [DEPTH-1:0] w_cand;

  stq_pkg::strb_t w_strb;
  stq_pkg::data_t w_data;

  assign w_ld_mask = stq_pkg::size_strb(i_fwd_size) << i_fwd_paddr[OFF_W-1:0];

  // ========================================
  // Candidate entries
  // ========================================
  for (genvar g = 0; g < DEPTH; g++) begin : g_ent
    logic w_same_line;

    assign w_ent_mask[g] = stq_pkg::size_strb(view.entries[g].size)
                           << view.entries[g].paddr[OFF_W-1:0];
    assign w_ent_data[g] = view.entries[g].data
                           << {view.entries[g].paddr[OFF_W-1:0], 3'b000};
    assign w_same_line   = (view.entries[g].paddr[stq_pkg::PADDR_W-1:OFF_W] ==
                            i_fwd_paddr[stq_pkg::PADDR_W-1:OFF_W]);

    assign w_cand[g] = i_fwd_valid &
                       view.entries[g].valid &
                       view.entries[g].upd_valid &
                       w_same_line &
                       (|(w_ent_mask[g] & w_ld_mask));
  end

  // ========================================
  // Youngest match per byte
  // ========================================
  // Walk from head to tail, so a younger store overrides an older one
  always_comb begin
    logic [IDX_W-1:0] idx;
    w_strb = '0;
    w_data = '0;
    for (int k = 0; k < DEPTH; k++) begin
      idx = view.head_idx + IDX_W'(k);
      for (int b = 0; b < stq_pkg::LINE_B; b++) begin
        if (w_cand[idx] && w_ent_mask[idx][b] && w_ld_mask[b]) begin
          w_strb[b]         = 1'b1;
          w_data[b*8 +: 8]  = w_ent_data[idx][b*8 +: 8];
        end
      end
    end
  end

  assign o_fwd_strb = w_strb;
  assign o_fwd_data = w_data;
  assign o_fwd_hit  = |w_strb;

endmodule

// ==== store_queue/stq_entry_array.sv ====
`timescale 1ns/1ps

module stq_entry_array #(
  parameter int DEPTH = stq_pkg::DEPTH_DEFAULT
) (
  input  logic                       i_clk,
  input  logic                       i_reset_n,

  input  logic                       i_alloc_valid,
  output logic [$clog2(DEPTH)-1:0]   o_alloc_idx,
  output logic                       o_full,

  input  logic                       i_upd_valid,
  input  logic [$clog2(DEPTH)-1:0]   i_upd_idx,
  input  stq_pkg::paddr_t            i_upd_paddr,
  input  stq_pkg::size_e             i_upd_size,
  input  stq_pkg::data_t             i_upd_data,

  input  logic                       i_commit_valid,

  input  logic                       i_release_valid,
  input  logic [1:0]                 i_release_cnt,

  stq_view_if.owner                  view
);

  localparam int IDX_W = $clog2(DEPTH);
  localparam int CNT_W = IDX_W + 1;

  // ========================================
  // State
  // ========================================
  logic [IDX_W-1:0] r_in_ptr;
  logic [IDX_W-1:0] r_cmt_ptr;
  logic [IDX_W-1:0] r_head_ptr;
  logic [CNT_W-1:0] r_count;

  logic [DEPTH-1:0] r_valid;
  logic [DEPTH-1:0] r_upd;
  logic [DEPTH-1:0] r_cmt;

  stq_pkg::size_e   r_size  [DEPTH];
  stq_pkg::paddr_t  r_paddr [DEPTH];
  stq_pkg::data_t   r_data  [DEPTH];

  logic             w_alloc;
  logic [IDX_W-1:0] w_head_nxt1;
  logic [CNT_W-1:0] w_rel_num;

  assign w_alloc     = i_alloc_valid & ~o_full;
  assign w_head_nxt1 = r_head_ptr + IDX_W'(1);
  assign w_rel_num   = i_release_valid ? CNT_W'(i_release_cnt) : '0;

  // ========================================
  // Pointers and count
  // ========================================
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_in_ptr   <= '0;
      r_cmt_ptr  <= '0;
      r_head_ptr <= '0;
      r_count    <= '0;
    end else begin
      if (w_alloc)        r_in_ptr  <= r_in_ptr + IDX_W'(1);
      if (i_commit_valid) r_cmt_ptr <= r_cmt_ptr + IDX_W'(1);
      if (i_release_valid) begin
        r_head_ptr <= r_head_ptr + IDX_W'(i_release_cnt);  // Wraps on power of two
      end
      r_count <= r_count + CNT_W'(w_alloc) - w_rel_num;
    end
  end

  // Per-entry status bits
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
      r_upd   <= '0;
      r_cmt   <= '0;
    end else begin
      for (int i = 0; i < DEPTH; i++) begin
        if (w_alloc && (r_in_ptr == IDX_W'(i))) begin
          r_valid[i] <= 1'b1;
          r_upd[i]   <= 1'b0;
          r_cmt[i]   <= 1'b0;
        end else if (i_release_valid && ((r_head_ptr == IDX_W'(i)) ||
                     ((i_release_cnt == 2'd2) && (w_head_nxt1 == IDX_W'(i))))) begin
          r_valid[i] <= 1'b0;
          r_upd[i]   <= 1'b0;
          r_cmt[i]   <= 1'b0;
        end else begin
          if (i_upd_valid && (i_upd_idx == IDX_W'(i)))     r_upd[i] <= 1'b1;
          if (i_commit_valid && (r_cmt_ptr == IDX_W'(i)))  r_cmt[i] <= 1'b1;
        end
      end
    end
  end

  // Payload
  always_ff @(posedge i_clk) begin
    if (w_alloc) begin
      r_size[r_in_ptr]  <= stq_pkg::SIZE_B;
      r_paddr[r_in_ptr] <= '0;
      r_data[r_in_ptr]  <= '0;
    end
    if (i_upd_valid) begin
      r_size[i_upd_idx]  <= i_upd_size;
      r_paddr[i_upd_idx] <= i_upd_paddr;
      r_data[i_upd_idx]  <= i_upd_data;
    end
  end

  // ========================================
  // Outputs
  // ========================================
  for (genvar g = 0; g < DEPTH; g++) begin : g_view
    assign view.entries[g] = '{
      valid:     r_valid[g],
      upd_valid: r_upd[g],
      committed: r_cmt[g],
      size:      r_size[g],
      paddr:     r_paddr[g],
      data:      r_data[g]
    };
  end

  assign view.head_idx = r_head_ptr;
  assign view.count    = r_count;

  assign o_alloc_idx = r_in_ptr;
  assign o_full      = (r_count == CNT_W'(DEPTH));

endmodule

// ==== common/stq_view_if.sv ====
`timescale 1ns/1ps

interface stq_view_if #(
  parameter int DEPTH = stq_pkg::DEPTH_DEFAULT
);

  localparam int IDX_W = $clog2(DEPTH);

  stq_pkg::stq_entry_t entries [DEPTH];
  logic [IDX_W-1:0]    head_idx;  // Oldest entry
  logic [IDX_W:0]      count;     // Valid entries

  modport owner (
    output entries,
    output head_idx,
    output count
  );

  modport reader (
    input entries,
    input head_idx,
    input count
  );

endinterface

// ==== common/stq_pkg.sv ====
package stq_pkg;

  // ========================================
  // Sizes
  // ========================================
  parameter int DEPTH_DEFAULT = 8;
  parameter int PADDR_W       = 32;
  parameter int LINE_B        = 8;               // Bytes per store-buffer line
  parameter int DATA_W        = LINE_B * 8;
  parameter int OFF_W         = $clog2(LINE_B);  // Byte offset inside a line

  typedef logic [PADDR_W-1:0] paddr_t;
  typedef logic [DATA_W-1:0]  data_t;            // Right-aligned store data
  typedef logic [LINE_B-1:0]  strb_t;

  // Access size as log2 of the byte count
  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2,
    SIZE_D = 2'd3
  } size_e;

  // ========================================
  // Queue entry
  // ========================================
  typedef struct packed {
    logic   valid;
    logic   upd_valid;   // Address and data known
    logic   committed;
    size_e  size;
    paddr_t paddr;
    data_t  data;
  } stq_entry_t;

  // Byte strobe for a size before the offset shift
  function automatic strb_t size_strb(size_e size);
    strb_t strb;
    case (size)
      SIZE_B:  strb = 8'h01;
      SIZE_H:  strb = 8'h03;
      SIZE_W:  strb = 8'h0f;
      default: strb = 8'hff;
    endcase
    return strb;
  endfunction

endpackage
